// ==== list.f ====
+incdir+.
photon_pkg.sv
photon_bus.sv
photon_core.sv
photon_regs.sv
photon_perm.sv
photon_top.sv
tb_photon.sv

// ==== Makefile ====
# Verilator build and run of the PHOTON coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_photon
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard *.sv *.svh) $(FLIST)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_photon.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "photon_defs.svh"

module tb_photon;

    localparam int STALL_LIMIT = 100;
    localparam int WB_LIMIT    = 20;
    localparam int POLL_LIMIT  = 50;

    // PRESENT s-box plus the round and internal constants for d = 5
    localparam logic [3:0] SBOX [16] = '{4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
                                         4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2};
    localparam logic [3:0] RC [12]   = '{4'h1, 4'h3, 4'h7, 4'hE, 4'hD, 4'hB,
                                         4'h6, 4'hC, 4'h9, 4'h2, 4'h5, 4'hA};
    localparam logic [3:0] IC [5]    = '{4'h0, 4'h1, 4'h3, 4'h6, 4'h4};

    logic        clk;
    logic        rst_n;
    logic        ins_valid;
    logic        ins_ready;
    logic [31:0] ins;
    logic [31:0] rs1_data;
    logic        rd_valid;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;

    logic [31:0] model [`PHOTON_NREGS];   // mirror of the photon registers
    logic [31:0] exp_data [$];
    logic [4:0]  exp_addr [$];
    int          exp_cyc [$];
    bit          exp_any [$];
    logic [31:0] e_data;
    logic [4:0]  e_addr;
    int          e_cyc;
    bit          e_any;
    logic [31:0] last_data;
    int          cyc = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    photon_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins_ready (ins_ready),
        .ins       (ins),
        .rs1_data  (rs1_data),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // multiply by x modulo x^4 + x + 1
    function automatic logic [3:0] xtime(input logic [3:0] a);
        return {a[2:0], 1'b0} ^ {2'b00, a[3], a[3]};
    endfunction

    function automatic logic [3:0] mul9(input logic [3:0] a);
        return xtime(xtime(xtime(a))) ^ a;
    endfunction

    function automatic logic [99:0] ref_photon80(input logic [99:0] s_in);
        logic [3:0]  c [5][5];
        logic [3:0]  m [5][5];
        logic [3:0]  z;
        logic [99:0] s;
        s = s_in;
        for (int r = 0; r < `PHOTON_ROUNDS; r++)
        begin
            for (int k = 0; k < 25; k++)
                c[k/5][k%5] = s[4*k +: 4];
            for (int i = 0; i < 5; i++)
                c[i][0] = c[i][0] ^ RC[r] ^ IC[i];
            // sbox is cellwise so it commutes with the row rotation
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    m[i][j] = SBOX[c[i][(j+i)%5]];
            for (int j = 0; j < 5; j++)
            begin
                repeat (5)
                begin
                    z = m[0][j] ^ xtime(m[1][j]) ^ mul9(m[2][j]) ^ mul9(m[3][j])
                        ^ xtime(m[4][j]);
                    for (int i = 0; i < 4; i++)
                        m[i][j] = m[i+1][j];
                    m[4][j] = z;
                end
            end
            for (int k = 0; k < 25; k++)
                s[4*k +: 4] = m[k/5][k%5];
        end
        return s;
    endfunction

    function automatic logic [31:0] xfer_word(input logic [4:0] funct, input logic [4:0] rd,
                                              input logic [2:0] preg);
        return {rd, 2'b00, preg, 10'd0, funct, `PHOTON_CUSTOM1};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [4:0] funct, input logic [4:0] rd);
        return {rd, 15'd0, funct, `PHOTON_CUSTOM1};
    endfunction

    task automatic abort(input string why);
        errors++;
        $display("%s", why);
        $display(">>> FAIL");
        $finish;
    endtask

    // holds ins_valid until accepted and queues the expected writeback
    task automatic issue(input logic [31:0] word, input logic [31:0] data, input bit wb,
                         input logic [4:0] rd, input logic [31:0] value, input bit any,
                         output int stalls);
        ins       = word;
        rs1_data  = data;
        ins_valid = 1'b1;
        stalls    = 0;
        @(negedge clk);
        while (!ins_ready && stalls < STALL_LIMIT)
        begin
            @(negedge clk);
            stalls++;
        end
        if (!ins_ready)
            abort("timeout: ins_ready stayed low while an instruction was pending");
        else
        begin
            if (wb)
            begin
                exp_data.push_back(value);
                exp_addr.push_back(rd);
                exp_cyc.push_back(cyc + 1);  // one cycle after the accepting edge
                exp_any.push_back(any);
            end
            @(posedge clk);
            #2;
            ins_valid = 1'b0;
            ins       = '0;
            rs1_data  = '0;
        end
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < WB_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (exp_data.size() != 0)
            abort("timeout: an expected writeback never arrived");
        else if (n > 0)
            #2;
    endtask

    task automatic write_reg(input int idx, input logic [31:0] value);
        int st;
        issue(xfer_word(`FUNCT_WRITE, 5'd0, 3'(idx)), value, 1'b0, '0, '0, 1'b0, st);
        model[idx] = value;
    endtask

    task automatic read_reg(input int idx);
        logic [4:0] rd;
        int         st;
        rd = 5'($urandom());
        issue(xfer_word(`FUNCT_READ, rd, 3'(idx)), '0, 1'b1, rd, model[idx], 1'b0, st);
    endtask

    task automatic read_all();
        for (int i = 0; i < `PHOTON_NREGS; i++)
            read_reg(i);
        wait_results();
    endtask

    task automatic start_hash();
        logic [99:0] s;
        int          st;
        issue(ctrl_word(`FUNCT_HASH, 5'd0), '0, 1'b0, '0, '0, 1'b0, st);
        s = ref_photon80({model[3][3:0], model[2], model[1], model[0]});
        model[0] = s[31:0];
        model[1] = s[63:32];
        model[2] = s[95:64];
        model[3] = {28'd0, s[99:96]};
    endtask

    // CHECK until the engine reports idle
    task automatic wait_idle();
        int polls;
        int st;
        polls     = 0;
        last_data = '0;
        while (last_data != 32'd1 && polls < POLL_LIMIT)
        begin
            issue(ctrl_word(`FUNCT_CHECK, 5'd3), '0, 1'b1, 5'd3, '0, 1'b1, st);
            wait_results();
            polls++;
        end
        if (last_data != 32'd1)
            abort("timeout: the engine stayed busy after repeated CHECK polls");
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    always @(negedge clk)
    begin
        if (rst_n && rd_valid)
        begin
            if (exp_data.size() == 0)
            begin
                errors++;
                $display("unexpected writeback to x%0d at %0t ns", rd_addr, $time);
            end
            else
            begin
                e_data = exp_data.pop_front();
                e_addr = exp_addr.pop_front();
                e_cyc  = exp_cyc.pop_front();
                e_any  = exp_any.pop_front();
                assert (rd_addr == e_addr)
                else
                begin
                    errors++;
                    $display("** Error at %0t ns: rd_addr %0d, expected %0d",
                             $time, rd_addr, e_addr);
                end
                assert (e_any || rd_data == e_data)
                else
                begin
                    errors++;
                    $display("** Error at %0t ns: rd_data %h, expected %h",
                             $time, rd_data, e_data);
                end
                assert (cyc == e_cyc)
                else
                begin
                    errors++;
                    $display("** Error at %0t ns: writeback in cycle %0d, expected %0d",
                             $time, cyc, e_cyc);
                end
                last_data = rd_data;
            end
        end
    end

    initial
    begin
        int          e0;
        int          st;
        int          j;
        int          tmp;
        int          order [`PHOTON_NREGS];
        logic [31:0] v;
        void'($urandom(47161));
        rst_n     = 1'b0;
        ins_valid = 1'b0;
        ins       = '0;
        rs1_data  = '0;
        for (int i = 0; i < `PHOTON_NREGS; i++)
            model[i] = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e0 = errors;
        read_all();
        issue(ctrl_word(`FUNCT_CHECK, 5'd7), '0, 1'b1, 5'd7, 32'd1, 1'b0, st);
        wait_results();
        finish_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < `PHOTON_NREGS; i++)
            write_reg(i, $urandom());
        for (int i = 0; i < `PHOTON_NREGS; i++)
            order[i] = i;
        for (int i = `PHOTON_NREGS - 1; i > 0; i--)
        begin
            j        = $urandom() % (i + 1);   // shuffle the read order
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < `PHOTON_NREGS; i++)
            read_reg(order[i]);
        wait_results();
        finish_test("write and read", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++)
            write_reg(i, $urandom());
        start_hash();
        wait_idle();
        read_all();
        finish_test("hash result", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++)
            write_reg(i, $urandom());
        start_hash();
        issue(ctrl_word(`FUNCT_CHECK, 5'd9), '0, 1'b1, 5'd9, 32'd0, 1'b0, st);
        v = $urandom();
        issue(xfer_word(`FUNCT_WRITE, 5'd0, 3'd5), v, 1'b0, '0, '0, 1'b0, st);
        model[5] = v;
        assert (st > 0)
        else
        begin
            errors++;
            $display("** Error at %0t ns: WRITE during HASH was not stalled", $time);
        end
        wait_idle();
        read_all();
        finish_test("busy stall", e0);

        e0 = errors;
        v = xfer_word(`FUNCT_WRITE, 5'd0, 3'd2);
        v[6:0] = 7'b0001011;   // custom-0 belongs to another unit
        issue(v, $urandom(), 1'b0, '0, '0, 1'b0, st);
        v = xfer_word(`FUNCT_READ, 5'd4, 3'd1);
        v[6:0] = 7'b0110011;
        issue(v, '0, 1'b0, '0, '0, 1'b0, st);
        issue(ctrl_word(5'b11111, 5'd6), $urandom(), 1'b0, '0, '0, 1'b0, st);
        issue(xfer_word(5'b00000, 5'd2, 3'd6), $urandom(), 1'b0, '0, '0, 1'b0, st);
        read_all();
        finish_test("illegal instructions", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++)
            write_reg(i, $urandom());
        start_hash();
        start_hash();   // stalls until the first hash is written back
        wait_idle();
        read_all();
        finish_test("chained hashes", e0);

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== photon_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module photon_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ins_valid,
    output logic        ins_ready,
    input  logic [31:0] ins,
    input  logic [31:0] rs1_data,
    output logic        rd_valid,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_data
);
    import photon_pkg::*;

    photon_state_t state;
    photon_state_t state_next;
    logic          state_we;

    photon_bus bus ();

    photon_core u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins_ready (ins_ready),
        .ins       (ins),
        .rs1_data  (rs1_data),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .bus       (bus)
    );

    photon_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .state      (state),
        .state_next (state_next),
        .state_we   (state_we)
    );

    photon_perm u_perm (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .state      (state),
        .state_next (state_next),
        .state_we   (state_we)
    );

endmodule

`default_nettype wire

// ==== photon_perm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "photon_defs.svh"

module photon_perm (
    input  logic                      clk,
    input  logic                      rst_n,
    photon_bus.perm                   bus,
    input  photon_pkg::photon_state_t state,
    output photon_pkg::photon_state_t state_next,
    output logic                      state_we
);
    import photon_pkg::*;

    // nibble tables with entry k at bits 4k+3..4k
    localparam logic [63:0] SBOX_TAB = 64'h2174_8FE3_DA09_B65C;  // PRESENT
    localparam logic [47:0] RC_TAB   = 48'hA529_C6BD_E731;
    localparam logic [19:0] IC_TAB   = 20'h46310;                // d = 5

    photon_state_t st;
    logic [3:0]    round;
    logic          busy;
    logic          done;

    // GF(16) multiply modulo x^4 + x + 1
    function automatic logic [3:0] gf_mul(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] p;
        logic [3:0] x;
        p = '0;
        x = a;
        for (int i = 0; i < 4; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[2:0], 1'b0} ^ (x[3] ? 4'h3 : 4'h0);
        end
        return p;
    endfunction

    function automatic photon_state_t p_round(input photon_state_t s, input logic [3:0] rc);
        logic [3:0]    c [`PHOTON_D][`PHOTON_D];
        logic [3:0]    t [`PHOTON_D][`PHOTON_D];
        logic [3:0]    acc;
        photon_state_t o;
        for (int i = 0; i < `PHOTON_D; i++)
            for (int j = 0; j < `PHOTON_D; j++)
                c[i][j] = s[4*(`PHOTON_D*i+j) +: 4];
        // AddConstants on column 0 before SubCells
        for (int i = 0; i < `PHOTON_D; i++)
            c[i][0] = c[i][0] ^ rc ^ IC_TAB[4*i +: 4];
        for (int i = 0; i < `PHOTON_D; i++)
            for (int j = 0; j < `PHOTON_D; j++)
                c[i][j] = SBOX_TAB[4*c[i][j] +: 4];
        for (int i = 0; i < `PHOTON_D; i++)
            for (int j = 0; j < `PHOTON_D; j++)
                t[i][j] = c[i][(j+i) % `PHOTON_D];   // row i rotates left by i
        // MixColumnsSerial applies Serial(1,2,9,9,2) d times
        for (int j = 0; j < `PHOTON_D; j++)
        begin
            for (int n = 0; n < `PHOTON_D; n++)
            begin
                acc = t[0][j] ^ gf_mul(4'h2, t[1][j]) ^ gf_mul(4'h9, t[2][j])
                      ^ gf_mul(4'h9, t[3][j]) ^ gf_mul(4'h2, t[4][j]);
                for (int i = 0; i < `PHOTON_D - 1; i++)
                    t[i][j] = t[i+1][j];
                t[`PHOTON_D-1][j] = acc;
            end
        end
        for (int i = 0; i < `PHOTON_D; i++)
            for (int j = 0; j < `PHOTON_D; j++)
                o[4*(`PHOTON_D*i+j) +: 4] = t[i][j];
        return o;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy  <= 1'b0;
            done  <= 1'b0;
            round <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (busy)
            begin
                round <= round + 4'd1;
                if (round == 4'(`PHOTON_ROUNDS - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;  // writeback pulse
                end
            end
            else if (bus.opcode == HASH)
            begin
                busy  <= 1'b1;
                round <= '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (busy)
            st <= p_round(st, RC_TAB[4*round +: 4]);
        else if (bus.opcode == HASH)
            st <= state_we ? st : state;  // regs not yet updated during writeback
    end

    assign state_next = st;
    assign state_we   = done;
    assign bus.ready  = !busy;

endmodule

`default_nettype wire

// ==== photon_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "photon_defs.svh"

module photon_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    photon_bus.regs                   bus,
    output photon_pkg::photon_state_t state,
    input  photon_pkg::photon_state_t state_next,
    input  logic                      state_we
);
    import photon_pkg::*;

    logic [31:0] regs [`PHOTON_NREGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `PHOTON_NREGS; i++)
                regs[i] <= '0;
        end
        else
        begin
            // hash result lands in regs 0..3
            if (state_we)
            begin
                regs[0] <= state_next[31:0];
                regs[1] <= state_next[63:32];
                regs[2] <= state_next[95:64];
                regs[3] <= {28'd0, state_next[99:96]};  // upper bits cleared
            end
            // a write accepted in the same cycle is the newer one
            if (bus.opcode == WRITE)
                regs[bus.addr] <= bus.data_in;
        end
    end

    assign bus.data_out = regs[bus.addr];

    assign state = {regs[3][3:0], regs[2], regs[1], regs[0]};

endmodule

`default_nettype wire

// ==== photon_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "photon_defs.svh"

module photon_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ins_valid,
    output logic                    ins_ready,
    input  photon_pkg::photon_ins_u ins,
    input  logic [31:0]             rs1_data,
    output logic                    rd_valid,
    output logic [4:0]              rd_addr,
    output logic [31:0]             rd_data,
    photon_bus.core                 bus
);
    import photon_pkg::*;

    photon_opcode_e dec_op;
    logic [4:0]     dec_rd;
    logic           custom1;
    logic           needs_engine;
    logic           accept;
    logic           wb_en;

    assign custom1 = (ins.ctrl.opcode == `PHOTON_CUSTOM1);

    always_comb
    begin
        dec_op = NONE;
        dec_rd = '0;
        if (custom1)
        begin
            case (ins.ctrl.funct5)
                `FUNCT_WRITE: dec_op = WRITE;
                `FUNCT_READ:
                begin
                    dec_op = READ;
                    dec_rd = ins.xfer.core_reg;
                end
                `FUNCT_HASH:  dec_op = HASH;
                `FUNCT_CHECK:
                begin
                    dec_op = CHECK;
                    dec_rd = ins.ctrl.core_reg;
                end
                default:      dec_op = NONE;   // unused funct5 is dropped
            endcase
        end
    end

    // only CHECK may pass a busy engine
    assign needs_engine = (dec_op != NONE) && (dec_op != CHECK);
    assign ins_ready    = bus.ready || !needs_engine;
    assign accept       = ins_valid && ins_ready;
    assign wb_en        = accept && ((dec_op == READ) || (dec_op == CHECK));

    assign bus.opcode  = accept ? dec_op : NONE;
    assign bus.addr    = accept ? ins.xfer.photon_reg : '0;
    assign bus.data_in = accept ? rs1_data : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= wb_en;
    end

    // writeback payload lands one cycle after accept
    always_ff @(posedge clk)
    begin
        if (wb_en)
        begin
            rd_addr <= dec_rd;
            rd_data <= (dec_op == READ) ? bus.data_out : {31'd0, bus.ready};
        end
    end

endmodule

`default_nettype wire

// ==== photon_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "photon_defs.svh"

interface photon_bus;
    import photon_pkg::*;

    photon_opcode_e                      opcode;   // NONE outside the accept cycle
    logic [$clog2(`PHOTON_NREGS)-1:0]    addr;
    logic [31:0]                         data_in;
    logic [31:0]                         data_out;
    logic                                ready;    // engine idle

    modport core (
        output opcode,
        output addr,
        output data_in,
        input  data_out,
        input  ready
    );

    modport regs (
        input  opcode,
        input  addr,
        input  data_in,
        output data_out
    );

    modport perm (
        input  opcode,
        output ready
    );

endinterface

`default_nettype wire

// ==== photon_pkg.sv ====
`default_nettype none

`include "photon_defs.svh"

package photon_pkg;

    typedef enum logic [2:0] {
        NONE,
        WRITE,
        READ,
        HASH,
        CHECK
    } photon_opcode_e;

    // READ / WRITE layout
    typedef struct packed {
        logic [4:0] core_reg;
        logic [1:0] unused_hi;
        logic [2:0] photon_reg;
        logic [9:0] unused_lo;
        logic [4:0] funct5;
        logic [6:0] opcode;
    } photon_xfer_t;

    // CHECK / HASH layout
    typedef struct packed {
        logic [4:0]  core_reg;
        logic [14:0] unused;
        logic [4:0]  funct5;
        logic [6:0]  opcode;
    } photon_ctrl_t;

    typedef union packed {
        photon_xfer_t xfer;
        photon_ctrl_t ctrl;
    } photon_ins_u;

    // cell k = 5*row + col at bits 4k+3..4k
    typedef logic [`PHOTON_STATE_W-1:0] photon_state_t;

endpackage

`default_nettype wire

// ==== photon_defs.svh ====
`ifndef PHOTON_DEFS_SVH
`define PHOTON_DEFS_SVH

// custom-1 major opcode
`define PHOTON_CUSTOM1 7'b0101011

// funct5 codes at ins[11:7]
`define FUNCT_READ  5'b00001
`define FUNCT_WRITE 5'b00010
`define FUNCT_HASH  5'b00011
`define FUNCT_CHECK 5'b00100

`define PHOTON_NREGS   8
`define PHOTON_ROUNDS  12
`define PHOTON_STATE_W 100

// PHOTON-80 state is d x d cells of 4 bits
`define PHOTON_D 5

`endif
